// ==== dv/ccc_tb.sv ====
// Bus model serves one held request at a time and expects MaxIbiPayload left at 0xFF
`timescale 1ns/1ps

module ccc_tb
  import i3c_ccc_pkg::*;
  import ccc_bus_pkg::*;
();

  localparam int NumRows = 14;
  localparam logic [6:0] DynAddr = 7'h2C;
  localparam logic [6:0] StaAddr = 7'h3A;
  localparam logic [6:0] OtherAddr = 7'h55;
  // CSR read values
  localparam logic [7:0] Bcr = 8'h66;
  localparam logic [7:0] Dcr = 8'hC4;
  localparam logic [15:0] Status = 16'h8001;
  localparam logic [15:0] Mwl = 16'h0100;
  localparam logic [15:0] Mrl = 16'h0040;
  localparam logic [47:0] Pid = 48'h1122_3344_5566;

  // Which strobe a row expects
  typedef enum logic [2:0] {KindNone, KindEnec, KindDisec, KindDyn, KindRstdaa} kind_e;

  typedef struct packed {
    logic [7:0] code;
    logic [7:0] addr;
    logic [7:0] data;
    logic       abort;
    logic       dyn_ok;
    kind_e      kind;
    logic [7:0] value;
    logic [2:0] nbytes;
  } row_t;

  logic         clk = 1'b0;
  logic         rst_n;
  logic [7:0]   ccc;
  logic         ccc_valid;
  bus_evt_t     bus_evt;
  target_addr_t target_addr;
  bus_req_t     bus_req;
  logic         done;
  evt_ctrl_t    enec;
  evt_ctrl_t    disec;
  logic         enec_valid;
  logic         disec_valid;
  logic [6:0]   dyn_addr;
  logic         dyn_addr_valid;
  logic         rstdaa;
  row_t         rows [NumRows];
  logic [31:0]  rng;
  // Pulse counters for enec, disec, dyn_addr, rstdaa, done and tx request cycles
  int           cnt [6] = '{default: 0};
  int           base [6];
  logic [7:0]   seen [3];
  int           cycle = 0;
  int           rstdaa_cyc = 0;
  int           done_cyc = 0;

  always #20 clk = ~clk;

  ccc_top ccc_top_i (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .ccc_i            (ccc),
    .ccc_valid_i      (ccc_valid),
    .bus_evt_i        (bus_evt),
    .target_addr_i    (target_addr),
    .bcr_i            (Bcr),
    .dcr_i            (Dcr),
    .status_i         (Status),
    .mwl_i            (Mwl),
    .mrl_i            (Mrl),
    .pid_i            (Pid),
    .bus_req_o        (bus_req),
    .done_o           (done),
    .enec_o           (enec),
    .enec_valid_o     (enec_valid),
    .disec_o          (disec),
    .disec_valid_o    (disec_valid),
    .dyn_addr_o       (dyn_addr),
    .dyn_addr_valid_o (dyn_addr_valid),
    .rstdaa_o         (rstdaa)
  );

  // Columns are code, addr/RnW, data, abort, dyn valid, strobe kind, value and GET bytes
  initial begin
    rows[0]  = '{CccEnec, {DynAddr, 1'b0}, 8'h09, 1'b0, 1'b1, KindEnec, 8'h05, 3'd0};
    rows[1]  = '{CccDisec, {DynAddr, 1'b0}, 8'h02, 1'b0, 1'b1, KindDisec, 8'h02, 3'd0};
    // Other target gets no ACK
    rows[2]  = '{CccEnec, {OtherAddr, 1'b0}, 8'h0B, 1'b0, 1'b1, KindNone, 8'h00, 3'd0};
    rows[3]  = '{CccGetbcr, {DynAddr, 1'b1}, 8'h00, 1'b0, 1'b1, KindNone, 8'h00, 3'd1};
    rows[4]  = '{CccGetdcr, {DynAddr, 1'b1}, 8'h00, 1'b0, 1'b1, KindNone, 8'h00, 3'd1};
    rows[5]  = '{CccGetstatus, {DynAddr, 1'b1}, 8'h00, 1'b0, 1'b1, KindNone, 8'h00, 3'd2};
    rows[6]  = '{CccGetmwl, {DynAddr, 1'b1}, 8'h00, 1'b0, 1'b1, KindNone, 8'h00, 3'd2};
    rows[7]  = '{CccGetmrl, {DynAddr, 1'b1}, 8'h00, 1'b0, 1'b1, KindNone, 8'h00, 3'd3};
    rows[8]  = '{CccGetpid, {DynAddr, 1'b1}, 8'h00, 1'b0, 1'b1, KindNone, 8'h00, 3'd6};
    // Static address match only
    rows[9]  = '{CccSetdasa, {StaAddr, 1'b0}, 8'hB6, 1'b0, 1'b0, KindDyn, 8'h5B, 3'd0};
    rows[10] = '{CccSetaasa, 8'h00, 8'h00, 1'b0, 1'b1, KindDyn, {1'b0, StaAddr}, 3'd0};
    rows[11] = '{CccRstdaa, 8'h00, 8'h00, 1'b0, 1'b1, KindRstdaa, 8'h00, 3'd0};
    // STOP between the data byte and its T-bit
    rows[12] = '{CccEnec, {DynAddr, 1'b0}, 8'h0B, 1'b1, 1'b1, KindNone, 8'h00, 3'd0};
    rows[13] = '{CccDisec, {DynAddr, 1'b0}, 8'h0B, 1'b0, 1'b1, KindDisec, 8'h07, 3'd0};
  end

  // Samples registered outputs and held requests at each edge
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (enec_valid) begin
      cnt[0] <= cnt[0] + 1;
      seen[0] <= {5'd0, enec};
    end
    if (disec_valid) begin
      cnt[1] <= cnt[1] + 1;
      seen[1] <= {5'd0, disec};
    end
    if (dyn_addr_valid) begin
      cnt[2] <= cnt[2] + 1;
      seen[2] <= {1'b0, dyn_addr};
    end
    if (rstdaa) begin
      cnt[3] <= cnt[3] + 1;
      rstdaa_cyc <= cycle;
    end
    if (done) begin
      cnt[4] <= cnt[4] + 1;
      done_cyc <= cycle;
    end
    if (bus_req.tx_bit || bus_req.tx_byte) begin
      cnt[5] <= cnt[5] + 1;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // GET byte idx with the most-significant byte first
  function automatic logic [7:0] resp_byte(input logic [7:0] code, input int idx);
    case (code)
      CccGetbcr:    return Bcr;
      CccGetdcr:    return Dcr;
      CccGetstatus: return (idx == 0) ? Status[15:8] : Status[7:0];
      CccGetmwl:    return (idx == 0) ? Mwl[15:8] : Mwl[7:0];
      // IBI payload limit last
      CccGetmrl:    return (idx == 2) ? 8'hFF : ((idx == 0) ? Mrl[15:8] : Mrl[7:0]);
      CccGetpid:    return 8'(Pid >> (40 - 8 * idx));
      default:      return 8'h00;
    endcase
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic check_equal(input string name, input int got, input int exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
      $display(">>> FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // Mask order rx_bit, rx_byte, tx_bit, tx_byte
  task automatic wait_req(input logic [3:0] mask);
    while (({bus_req.rx_bit, bus_req.rx_byte, bus_req.tx_bit, bus_req.tx_byte} & mask)
           == 4'd0) begin
      next_cycle();
    end
  endtask

  // 1 to 4 cycles
  task automatic random_wait();
    rng = xorshift32(rng);
    repeat (1 + int'(rng[1:0])) next_cycle();
  endtask

  task automatic answer_rx(input logic [3:0] mask, input logic [7:0] data);
    wait_req(mask);
    random_wait();
    bus_evt.rx_data = data;
    bus_evt.rx_done = 1'b1;
    next_cycle();
    bus_evt.rx_done = 1'b0;
  endtask

  task automatic answer_tx();
    random_wait();
    bus_evt.tx_done = 1'b1;
    next_cycle();
    bus_evt.tx_done = 1'b0;
  endtask

  task automatic send_rstart();
    bus_evt.rstart = 1'b1;
    next_cycle();
    bus_evt.rstart = 1'b0;
  endtask

  task automatic send_stop();
    bus_evt.stop = 1'b1;
    next_cycle();
    bus_evt.stop = 1'b0;
  endtask

  task automatic run_row(input int r);
    row_t row;
    logic match;
    int   n;
    int   i;
    row = rows[r];
    n = int'(row.nbytes);
    match = row.dyn_ok ? (row.addr[7:1] == DynAddr) : (row.addr[7:1] == StaAddr);
    target_addr.dyn_valid = row.dyn_ok;
    base = cnt;
    ccc = row.code;
    ccc_valid = 1'b1;
    next_cycle();
    ccc_valid = 1'b0;
    // T-bit request right after the code
    check_equal("bus_req.rx_bit", int'(bus_req.rx_bit), 1);
    answer_rx(4'b1000, 8'h00);
    if (!row.code[DirectBit]) begin
      while (!done) begin
        next_cycle();
      end
      send_stop();
    end else begin
      // Sr ends the defining byte phase
      wait_req(4'b0100);
      random_wait();
      send_rstart();
      answer_rx(4'b0100, row.addr);
      if (!match) begin
        repeat (3) next_cycle();
      end else begin
        wait_req(4'b0010);
        check_equal("bus_req.tx_value ack", int'(bus_req.tx_value[0]), 0);
        answer_tx();
        if (row.addr[0]) begin
          for (i = 0; i < n; i++) begin
            wait_req(4'b0001);
            check_equal("bus_req.tx_value byte", int'(bus_req.tx_value),
                        int'(resp_byte(row.code, i)));
            answer_tx();
            // T-bit high while bytes remain
            wait_req(4'b0010);
            check_equal("bus_req.tx_value tbit", int'(bus_req.tx_value[0]), int'(i + 1 < n));
            answer_tx();
          end
          check_equal("bus_req.rx_byte", int'(bus_req.rx_byte), 1);
        end else if (row.abort) begin
          answer_rx(4'b0100, row.data);
          wait_req(4'b1000);
          random_wait();
        end else begin
          answer_rx(4'b0100, row.data);
          answer_rx(4'b1000, 8'h00);
        end
      end
      // done_o two cycles after the STOP
      send_stop();
      next_cycle();
      check_equal("done_o", int'(done), 1);
    end
    repeat (2) next_cycle();
    check_equal("done_o pulses", cnt[4] - base[4], 1);
    check_equal("enec_valid_o pulses", cnt[0] - base[0], int'(row.kind == KindEnec));
    check_equal("disec_valid_o pulses", cnt[1] - base[1], int'(row.kind == KindDisec));
    check_equal("dyn_addr_valid_o pulses", cnt[2] - base[2], int'(row.kind == KindDyn));
    check_equal("rstdaa_o pulses", cnt[3] - base[3], int'(row.kind == KindRstdaa));
    if (!match && row.code[DirectBit]) begin
      check_equal("tx request cycles", cnt[5] - base[5], 0);
    end
    case (row.kind)
      KindEnec:   check_equal("enec_o", int'(seen[0]), int'(row.value));
      KindDisec:  check_equal("disec_o", int'(seen[1]), int'(row.value));
      KindDyn:    check_equal("dyn_addr_o", int'(seen[2]), int'(row.value));
      KindRstdaa: check_equal("rstdaa_o to done_o cycles", done_cyc - rstdaa_cyc, 1);
      default: ;
    endcase
  endtask

  initial begin
    rng = 32'hf489_c21f;
    rst_n = 1'b0;
    ccc = 8'h00;
    ccc_valid = 1'b0;
    bus_evt = '0;
    target_addr = '{sta_addr: StaAddr, sta_valid: 1'b1, dyn_addr: DynAddr, dyn_valid: 1'b1};
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    repeat (2) next_cycle();
    for (int r = 0; r < NumRows; r++) begin
      run_row(r);
    end
    $display(">>> PASS");
    $finish;
  end

  // Budget of 200 cycles per row
  initial begin
    repeat (NumRows * 200 + 20) @(posedge clk);
    $display("Timeout: the DUT stopped answering before all rows finished");
    $display(">>> FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== list.f ====
verilog/i3c_ccc_pkg.sv
verilog/ccc_bus_pkg.sv
verilog/ccc_sequencer.sv
verilog/ccc_get_responder.sv
verilog/ccc_set_actions.sv
verilog/ccc_top.sv
dv/ccc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator and run; the exit status follows the testbench
cd "$(dirname "$0")" &&
  verilator --binary --timing --timescale 1ns/1ps -f list.f --top-module ccc_tb \
    -o ccc_tb_sim &&
  ./obj_dir/ccc_tb_sim ||
  exit 1

// ==== verilog/ccc_bus_pkg.sv ====
// Bus layer answers each held request with exactly one rx_done or tx_done pulse
package ccc_bus_pkg;
  import i3c_ccc_pkg::*;

  // Requests toward the rx and tx layer
  // Held as levels until the matching done pulse
  typedef struct packed {
    logic       rx_bit;
    logic       rx_byte;
    logic       tx_bit;
    logic       tx_byte;
    // Bit 0 carries the value of a tx_bit request
    logic [7:0] tx_value;
  } bus_req_t;

  // Bus monitor conditions and rx/tx completion
  typedef struct packed {
    logic       start;
    logic       rstart;
    logic       stop;
    logic       rx_done;
    logic       tx_done;
    logic [7:0] rx_data;
  } bus_evt_t;

  // Static and dynamic target address
  typedef struct packed {
    logic [6:0] sta_addr;
    logic       sta_valid;
    logic [6:0] dyn_addr;
    logic       dyn_valid;
  } target_addr_t;

  // Event enable bits as carried by ENEC and DISEC
  typedef struct packed {
    logic ibi;
    logic crr;
    logic hj;
  } evt_ctrl_t;

  // Sequencer to consumers
  typedef struct packed {
    ccc_code_e  code;
    logic [7:0] data;
    logic       data_valid;
    logic       bcast_valid;
    logic       get_start;
    logic       tx_byte_done;
  } seq_evt_t;

  // Responder back to the sequencer
  typedef struct packed {
    logic [7:0] tx_byte;
    logic       last;
  } get_resp_t;

endpackage

// ==== verilog/ccc_get_responder.sv ====
// A read of a code without GET data returns one zero byte marked last
`timescale 1ns/1ps

module ccc_get_responder
  import i3c_ccc_pkg::*;
  import ccc_bus_pkg::*;
#(
  parameter logic [7:0] MaxIbiPayload = 8'hFF
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  seq_evt_t    seq_evt_i,
  input  logic [7:0]  bcr_i,
  input  logic [7:0]  dcr_i,
  input  logic [15:0] status_i,
  input  logic [15:0] mwl_i,
  input  logic [15:0] mrl_i,
  input  logic [47:0] pid_i,
  output get_resp_t   get_resp_o
);

  // Bytes left including the one on the bus
  logic [2:0]  count_q;
  logic [2:0]  count_init;
  // Response right aligned and sent MSB first
  logic [47:0] resp_word;
  logic [5:0]  shift_amt;

  always_comb begin
    count_init = 3'd0;
    resp_word  = '0;
    case (seq_evt_i.code)
      CccGetbcr: begin
        count_init = 3'd1;
        resp_word  = {40'd0, bcr_i};
      end
      CccGetdcr: begin
        count_init = 3'd1;
        resp_word  = {40'd0, dcr_i};
      end
      // Format 1 only
      CccGetstatus: begin
        count_init = 3'd2;
        resp_word  = {32'd0, status_i};
      end
      CccGetmwl: begin
        count_init = 3'd2;
        resp_word  = {32'd0, mwl_i};
      end
      // Third byte is the IBI payload limit
      CccGetmrl: begin
        count_init = 3'd3;
        resp_word  = {24'd0, mrl_i, MaxIbiPayload};
      end
      CccGetpid: begin
        count_init = 3'd6;
        resp_word  = pid_i;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (seq_evt_i.get_start) begin
      count_q <= count_init;
    end else if (seq_evt_i.tx_byte_done && count_q != 3'd0) begin
      count_q <= count_q - 3'd1;
    end
  end

  // Count of one selects the lowest byte
  assign shift_amt          = {count_q - 3'd1, 3'b000};
  assign get_resp_o.tx_byte = 8'(resp_word >> shift_amt);
  assign get_resp_o.last    = (count_q <= 3'd1);

endmodule

// ==== verilog/ccc_sequencer.sv ====
// Takes over right after the command code and only a STOP in an active state aborts it
`timescale 1ns/1ps

module ccc_sequencer
  import i3c_ccc_pkg::*;
  import ccc_bus_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic [7:0]   ccc_i,
  input  logic         ccc_valid_i,
  input  bus_evt_t     bus_evt_i,
  input  target_addr_t target_addr_i,
  input  get_resp_t    get_resp_i,
  output bus_req_t     bus_req_o,
  output seq_evt_t     seq_evt_o,
  output logic         done_o
);

  typedef enum logic [3:0] {
    Idle,
    WaitCcc,
    RxTbit,
    RxDefByte,
    RxDefTbit,
    RxAddr,
    TxAddrAck,
    RxData,
    RxDataTbit,
    TxData,
    TxDataTbit,
    HandleBcast,
    DoneCcc
  } state_e;

  state_e     state_q;
  state_e     state_d;
  logic [7:0] code_q;
  logic [6:0] addr_q;
  logic       rnw_q;
  logic [7:0] data_q;
  logic       done_q;
  logic       is_direct;
  logic       is_rsvd;
  logic       addr_match;
  logic       active;

  assign is_direct = code_q[DirectBit];
  // Broadcast address with write ends the direct CCC
  assign is_rsvd   = (addr_q == RsvdAddr) && !rnw_q;
  // Handler owns the bus only between code and done
  assign active    = (state_q != Idle) && (state_q != WaitCcc) && (state_q != DoneCcc);

  // Dynamic address wins once assigned
  always_comb begin
    if (target_addr_i.dyn_valid) begin
      addr_match = (addr_q == target_addr_i.dyn_addr);
    end else if (target_addr_i.sta_valid) begin
      addr_match = (addr_q == target_addr_i.sta_addr);
    end else begin
      addr_match = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      code_q <= '0;
    end else if (ccc_valid_i && (state_q == Idle || state_q == WaitCcc)) begin
      code_q <= ccc_i;
    end
  end

  // Address/RnW byte and write data byte
  always_ff @(posedge clk_i) begin
    if (state_q == RxAddr && bus_evt_i.rx_done) begin
      addr_q <= bus_evt_i.rx_data[7:1];
      rnw_q  <= bus_evt_i.rx_data[0];
    end
    if (state_q == RxData && bus_evt_i.rx_done) begin
      data_q <= bus_evt_i.rx_data;
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle:        state_d = ccc_valid_i ? RxTbit : WaitCcc;
      WaitCcc:     if (ccc_valid_i) state_d = RxTbit;
      // T-bit after the command code
      RxTbit:      if (bus_evt_i.rx_done) state_d = is_direct ? RxDefByte : HandleBcast;
      // Defining bytes are skipped until Sr
      RxDefByte: begin
        if (bus_evt_i.rstart) state_d = RxAddr;
        else if (bus_evt_i.rx_done) state_d = RxDefTbit;
      end
      RxDefTbit:   if (bus_evt_i.rx_done) state_d = RxDefByte;
      RxAddr:      if (bus_evt_i.rx_done) state_d = TxAddrAck;
      // Other targets' addresses get no ACK
      TxAddrAck: begin
        if (is_rsvd) state_d = DoneCcc;
        else if (!addr_match) state_d = RxAddr;
        else if (bus_evt_i.tx_done) state_d = rnw_q ? TxData : RxData;
      end
      RxData: begin
        if (bus_evt_i.rstart) state_d = RxAddr;
        else if (bus_evt_i.rx_done) state_d = RxDataTbit;
      end
      RxDataTbit:  if (bus_evt_i.rx_done) state_d = RxData;
      TxData: begin
        if (bus_evt_i.rstart) state_d = RxAddr;
        else if (bus_evt_i.tx_done) state_d = TxDataTbit;
      end
      // Last byte hands back to address phase
      TxDataTbit:  if (bus_evt_i.tx_done) state_d = get_resp_i.last ? RxAddr : TxData;
      HandleBcast: state_d = DoneCcc;
      DoneCcc:     state_d = Idle;
      default:     state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
      done_q  <= 1'b0;
    end else begin
      state_q <= (bus_evt_i.stop && active) ? DoneCcc : state_d;
      done_q  <= (state_q == DoneCcc);
    end
  end

  assign done_o = done_q;

  // Requests follow the state
  always_comb begin
    bus_req_o = '0;
    unique case (state_q)
      RxTbit, RxDefTbit, RxDataTbit: bus_req_o.rx_bit = 1'b1;
      // Drop the byte request as soon as Sr shows up
      RxDefByte:      bus_req_o.rx_byte = !bus_evt_i.rstart;
      RxAddr, RxData: bus_req_o.rx_byte = 1'b1;
      // ACK is a low bit
      TxAddrAck:      bus_req_o.tx_bit = addr_match && !is_rsvd;
      TxData: begin
        bus_req_o.tx_byte  = 1'b1;
        bus_req_o.tx_value = get_resp_i.tx_byte;
      end
      // T-bit high while more bytes follow
      TxDataTbit: begin
        bus_req_o.tx_bit   = 1'b1;
        bus_req_o.tx_value = {7'd0, !get_resp_i.last};
      end
      default: ;
    endcase
  end

  assign seq_evt_o.code         = ccc_code_e'(code_q);
  assign seq_evt_o.data         = data_q;
  assign seq_evt_o.data_valid   = (state_q == RxDataTbit) && bus_evt_i.rx_done;
  assign seq_evt_o.bcast_valid  = (state_q == HandleBcast);
  assign seq_evt_o.get_start    = (state_q == TxAddrAck) && addr_match && !is_rsvd &&
                                  rnw_q && bus_evt_i.tx_done;
  assign seq_evt_o.tx_byte_done = (state_q == TxDataTbit) && bus_evt_i.tx_done;

endmodule

// ==== verilog/ccc_set_actions.sv ====
// SETAASA is ignored while the static address is not valid
`timescale 1ns/1ps

module ccc_set_actions
  import i3c_ccc_pkg::*;
  import ccc_bus_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  seq_evt_t     seq_evt_i,
  input  target_addr_t target_addr_i,
  output evt_ctrl_t    enec_o,
  output logic         enec_valid_o,
  output evt_ctrl_t    disec_o,
  output logic         disec_valid_o,
  output logic [6:0]   dyn_addr_o,
  output logic         dyn_addr_valid_o,
  output logic         rstdaa_o
);

  logic enec_hit;
  logic disec_hit;
  logic dasa_hit;
  logic aasa_hit;
  logic rstdaa_hit;

  // ENEC/DISEC byte layout
  function automatic evt_ctrl_t decode_ctrl(input logic [7:0] data);
    evt_ctrl_t ctrl;
    ctrl.ibi = data[0];
    ctrl.crr = data[1];
    ctrl.hj  = data[3];
    return ctrl;
  endfunction

  // Direct writes qualify on the data T-bit
  assign enec_hit   = seq_evt_i.data_valid && (seq_evt_i.code == CccEnec);
  assign disec_hit  = seq_evt_i.data_valid && (seq_evt_i.code == CccDisec);
  assign dasa_hit   = seq_evt_i.data_valid && (seq_evt_i.code == CccSetdasa);
  // Broadcasts qualify in the handling cycle
  assign aasa_hit   = seq_evt_i.bcast_valid && (seq_evt_i.code == CccSetaasa) &&
                      target_addr_i.sta_valid;
  assign rstdaa_hit = seq_evt_i.bcast_valid && (seq_evt_i.code == CccRstdaa);

  // One-cycle strobes
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enec_valid_o     <= 1'b0;
      disec_valid_o    <= 1'b0;
      dyn_addr_valid_o <= 1'b0;
      rstdaa_o         <= 1'b0;
    end else begin
      enec_valid_o     <= enec_hit;
      disec_valid_o    <= disec_hit;
      dyn_addr_valid_o <= dasa_hit || aasa_hit;
      rstdaa_o         <= rstdaa_hit;
    end
  end

  // Values hold until the next strobe
  always_ff @(posedge clk_i) begin
    if (enec_hit) begin
      enec_o <= decode_ctrl(seq_evt_i.data);
    end
    if (disec_hit) begin
      disec_o <= decode_ctrl(seq_evt_i.data);
    end
    // SETDASA byte has the address in bits 7 to 1
    if (dasa_hit) begin
      dyn_addr_o <= seq_evt_i.data[7:1];
    end else if (aasa_hit) begin
      dyn_addr_o <= target_addr_i.sta_addr;
    end
  end

endmodule

// ==== verilog/ccc_top.sv ====
// CSR values are sampled live while response bytes go out and are not latched
`timescale 1ns/1ps

module ccc_top
  import ccc_bus_pkg::*;
#(
  parameter logic [7:0] MaxIbiPayload = 8'hFF
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  // Code from the primary target FSM
  input  logic [7:0]   ccc_i,
  input  logic         ccc_valid_i,
  input  bus_evt_t     bus_evt_i,
  input  target_addr_t target_addr_i,
  // CSR read values
  input  logic [7:0]   bcr_i,
  input  logic [7:0]   dcr_i,
  input  logic [15:0]  status_i,
  input  logic [15:0]  mwl_i,
  input  logic [15:0]  mrl_i,
  input  logic [47:0]  pid_i,
  output bus_req_t     bus_req_o,
  output logic         done_o,
  // CSR write strobes
  output evt_ctrl_t    enec_o,
  output logic         enec_valid_o,
  output evt_ctrl_t    disec_o,
  output logic         disec_valid_o,
  output logic [6:0]   dyn_addr_o,
  output logic         dyn_addr_valid_o,
  output logic         rstdaa_o
);

  seq_evt_t  seq_evt;
  get_resp_t get_resp;

  ccc_sequencer ccc_sequencer_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .ccc_i         (ccc_i),
    .ccc_valid_i   (ccc_valid_i),
    .bus_evt_i     (bus_evt_i),
    .target_addr_i (target_addr_i),
    .get_resp_i    (get_resp),
    .bus_req_o     (bus_req_o),
    .seq_evt_o     (seq_evt),
    .done_o        (done_o)
  );

  // Direct GET data
  ccc_get_responder #(
    .MaxIbiPayload (MaxIbiPayload)
  ) ccc_get_responder_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .seq_evt_i  (seq_evt),
    .bcr_i      (bcr_i),
    .dcr_i      (dcr_i),
    .status_i   (status_i),
    .mwl_i      (mwl_i),
    .mrl_i      (mrl_i),
    .pid_i      (pid_i),
    .get_resp_o (get_resp)
  );

  // SET and broadcast actions
  ccc_set_actions ccc_set_actions_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .seq_evt_i        (seq_evt),
    .target_addr_i    (target_addr_i),
    .enec_o           (enec_o),
    .enec_valid_o     (enec_valid_o),
    .disec_o          (disec_o),
    .disec_valid_o    (disec_valid_o),
    .dyn_addr_o       (dyn_addr_o),
    .dyn_addr_valid_o (dyn_addr_valid_o),
    .rstdaa_o         (rstdaa_o)
  );

endmodule

// ==== verilog/i3c_ccc_pkg.sv ====
// Only the kept CCC codes appear here and any other code value falls to default handling
package i3c_ccc_pkg;

  // Command codes handled by the target
  typedef enum logic [7:0] {
    // Broadcast codes have bit 7 clear
    CccRstdaa    = 8'h06,
    CccSetaasa   = 8'h29,
    // Direct SET codes
    CccEnec      = 8'h80,
    CccDisec     = 8'h81,
    CccSetdasa   = 8'h87,
    // Direct GET codes
    CccGetmwl    = 8'h8B,
    CccGetmrl    = 8'h8C,
    CccGetpid    = 8'h8D,
    CccGetbcr    = 8'h8E,
    CccGetdcr    = 8'h8F,
    CccGetstatus = 8'h90
  } ccc_code_e;

  // Set in the code for direct commands
  localparam int unsigned DirectBit = 7;

  // I3C broadcast address
  // Sent with RnW low it closes a direct CCC
  localparam logic [6:0] RsvdAddr = 7'h7E;

endpackage
